/* hdl/mpca_config.svh */
`ifndef MPCA_CONFIG_SVH
`define MPCA_CONFIG_SVH

// batch shape
`define MPCA_NUM_REQ      8
`define MPCA_NUM_CH       3

// field widths
`define MPCA_CAP_W        3
`define MPCA_SCORE_W      7
`define MPCA_WORD_W       16

// cipher rounds, one expanded key each
`define MPCA_KEY_ROUNDS   4

// flow control on both sides
`define MPCA_QUEUE_DEPTH  8
`define MPCA_OUT_CREDITS  2

// grant code meaning no channel
`define MPCA_NO_CH        3

`endif

/* hdl/mpca_pkg.sv */
`default_nettype none

`include "mpca_config.svh"

package mpca_pkg;

    // ====================
    // scalar types
    // ====================

    typedef logic [$clog2(`MPCA_NUM_REQ)-1:0] idx_t;
    typedef logic [1:0]                         ch_t;
    typedef logic [`MPCA_CAP_W-1:0]             cap_t;
    typedef logic signed [`MPCA_SCORE_W-1:0]    score_t;

    // one capacity per channel, channel 0 in the low bits
    typedef cap_t [`MPCA_NUM_CH-1:0] cap_vec_t;

    // ====================
    // batch types
    // ====================

    typedef struct packed {
        logic [`MPCA_NUM_REQ*`MPCA_WORD_W-1:0]    packets;
        cap_vec_t                                 capacity;
        logic [`MPCA_KEY_ROUNDS*`MPCA_WORD_W-1:0] key;
    } in_batch_t;

    // field order follows the decrypted word, bit 15 down to bit 1
    typedef struct packed {
        logic       valid;
        logic [1:0] qos;
        logic [3:0] len;
        logic [1:0] congestion;
        ch_t        prefer;
        logic [2:0] hint;
        logic       mode;
    } alloc_req_t;

    typedef struct packed {
        alloc_req_t [`MPCA_NUM_REQ-1:0] reqs;
        cap_vec_t                       capacity;
    } req_batch_t;

    // rank[0] holds the index of the highest request
    typedef struct packed {
        req_batch_t               batch;
        idx_t [`MPCA_NUM_REQ-1:0] rank;
    } ranked_batch_t;

    typedef ch_t [`MPCA_NUM_REQ-1:0] grant_vec_t;

endpackage

`default_nettype wire

/* hdl/packet_decrypt.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpca_config.svh"

module packet_decrypt (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mpca_pkg::in_batch_t  in_batch,
    output logic                 req_valid,
    output mpca_pkg::req_batch_t req
);
    import mpca_pkg::*;

    logic [`MPCA_WORD_W-1:0] key_sched [`MPCA_KEY_ROUNDS];
    alloc_req_t [`MPCA_NUM_REQ-1:0] dec_reqs;

    function automatic logic [`MPCA_WORD_W-1:0] rotr(input logic [`MPCA_WORD_W-1:0] v,
                                                     input int n);
        return (v >> n) | (v << (`MPCA_WORD_W - n));
    endfunction

    function automatic logic [`MPCA_WORD_W-1:0] rotl(input logic [`MPCA_WORD_W-1:0] v,
                                                     input int n);
        return (v << n) | (v >> (`MPCA_WORD_W - n));
    endfunction

    // ====================
    // key expansion
    // ====================

    always_comb begin
        key_sched[0] = in_batch.key[`MPCA_WORD_W-1:0];
        for (int r = 1; r < `MPCA_KEY_ROUNDS; r++) begin
            key_sched[r] = (rotr(key_sched[r-1], 7) + in_batch.key[r*`MPCA_WORD_W +: `MPCA_WORD_W])
                           ^ `MPCA_WORD_W'(r - 1);
        end
    end

    // ====================
    // rounds and decode
    // ====================

    // keys are applied last to first
    always_comb begin
        logic [`MPCA_WORD_W-1:0] x;
        logic [`MPCA_WORD_W-1:0] y;
        for (int w = 0; w < `MPCA_NUM_REQ / 2; w++) begin
            x = in_batch.packets[(2*w)*`MPCA_WORD_W +: `MPCA_WORD_W];
            y = in_batch.packets[(2*w+1)*`MPCA_WORD_W +: `MPCA_WORD_W];
            for (int r = `MPCA_KEY_ROUNDS - 1; r >= 0; r--) begin
                y = rotr(y ^ x, 2);
                x = rotl((x ^ key_sched[r]) - y, 7);
            end
            // bit 0 is spare
            dec_reqs[2*w]   = alloc_req_t'(x[`MPCA_WORD_W-1:1]);
            dec_reqs[2*w+1] = alloc_req_t'(y[`MPCA_WORD_W-1:1]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            req.reqs     <= dec_reqs;
            req.capacity <= in_batch.capacity;
        end
    end

endmodule

`default_nettype wire

/* hdl/priority_sort.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpca_config.svh"

module priority_sort (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  mpca_pkg::req_batch_t    req,
    output logic                    rank_valid,
    output mpca_pkg::ranked_batch_t ranked
);
    import mpca_pkg::*;

    score_t                   score [`MPCA_NUM_REQ];
    idx_t [`MPCA_NUM_REQ-1:0] order;

    // mode 1 reads every field as two's complement
    function automatic score_t calc_score(input alloc_req_t r);
        score_t qos_e;
        score_t len_e;
        score_t cong_e;
        score_t hint_e;
        qos_e  = {{(`MPCA_SCORE_W-2){r.mode & r.qos[1]}}, r.qos};
        len_e  = {{(`MPCA_SCORE_W-4){r.mode & r.len[3]}}, r.len};
        cong_e = {{(`MPCA_SCORE_W-2){r.mode & r.congestion[1]}}, r.congestion};
        hint_e = {{(`MPCA_SCORE_W-3){r.mode & r.hint[2]}}, r.hint};
        return (qos_e <<< 2) - (len_e <<< 1) - (cong_e + (cong_e <<< 1)) + hint_e
               + score_t'(7);
    endfunction

    // returns the pair with the winner in the upper field
    function automatic logic [2*$bits(idx_t)-1:0] order_pair(input idx_t a, input idx_t b);
        logic a_first;
        if (req.reqs[a].valid != req.reqs[b].valid) begin
            a_first = req.reqs[a].valid;
        end else if (score[a] != score[b]) begin
            a_first = score[a] > score[b];
        end else begin
            a_first = a < b;
        end
        return a_first ? {a, b} : {b, a};
    endfunction

    always_comb begin
        for (int i = 0; i < `MPCA_NUM_REQ; i++) begin
            score[i] = calc_score(req.reqs[i]);
        end
    end

    // ====================
    // sorting network
    // ====================

    // six layers, compare-exchange in place
    always_comb begin
        for (int i = 0; i < `MPCA_NUM_REQ; i++) begin
            order[i] = idx_t'(i);
        end
        // layer 0
        {order[0], order[2]} = order_pair(order[0], order[2]);
        {order[1], order[3]} = order_pair(order[1], order[3]);
        {order[4], order[6]} = order_pair(order[4], order[6]);
        {order[5], order[7]} = order_pair(order[5], order[7]);
        // layer 1
        {order[0], order[4]} = order_pair(order[0], order[4]);
        {order[1], order[5]} = order_pair(order[1], order[5]);
        {order[2], order[6]} = order_pair(order[2], order[6]);
        {order[3], order[7]} = order_pair(order[3], order[7]);
        // layer 2, ends of the order are final here
        {order[0], order[1]} = order_pair(order[0], order[1]);
        {order[2], order[3]} = order_pair(order[2], order[3]);
        {order[4], order[5]} = order_pair(order[4], order[5]);
        {order[6], order[7]} = order_pair(order[6], order[7]);
        // layer 3
        {order[2], order[4]} = order_pair(order[2], order[4]);
        {order[3], order[5]} = order_pair(order[3], order[5]);
        // layer 4
        {order[1], order[4]} = order_pair(order[1], order[4]);
        {order[3], order[6]} = order_pair(order[3], order[6]);
        // layer 5
        {order[1], order[2]} = order_pair(order[1], order[2]);
        {order[3], order[4]} = order_pair(order[3], order[4]);
        {order[5], order[6]} = order_pair(order[5], order[6]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rank_valid <= 1'b0;
        end else begin
            rank_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            ranked.batch <= req;
            ranked.rank  <= order;
        end
    end

endmodule

`default_nettype wire

/* hdl/channel_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpca_config.svh"

module channel_allocator (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rank_valid,
    input  mpca_pkg::ranked_batch_t ranked,
    output logic                    grant_valid,
    output mpca_pkg::grant_vec_t    grant_vec
);
    import mpca_pkg::*;

    grant_vec_t alloc;

    function automatic ch_t ch_step(input ch_t c, input int n);
        return ch_t'((int'(c) + n) % `MPCA_NUM_CH);
    endfunction

    // ====================
    // rank-ordered walk
    // ====================

    // pivot holds NO_CH until the first fallback of the batch
    always_comb begin
        cap_vec_t   cap;
        ch_t        pivot;
        ch_t        start;
        ch_t        probe;
        ch_t        ch;
        alloc_req_t cur;
        cap   = ranked.batch.capacity;
        pivot = ch_t'(`MPCA_NO_CH);
        start = '0;
        probe = '0;
        alloc = {`MPCA_NUM_REQ{ch_t'(`MPCA_NO_CH)}};
        for (int i = 0; i < `MPCA_NUM_REQ; i++) begin
            cur = ranked.batch.reqs[ranked.rank[i]];
            ch  = ch_t'(`MPCA_NO_CH);
            if (cur.valid) begin
                // code 3 is a channel that never has room
                if (cur.prefer != ch_t'(`MPCA_NO_CH) && cap[cur.prefer] != '0) begin
                    ch = cur.prefer;
                end else begin
                    if (pivot != ch_t'(`MPCA_NO_CH)) begin
                        start = pivot;
                    end else if (cur.prefer == ch_t'(`MPCA_NO_CH)) begin
                        start = '0;
                    end else begin
                        start = cur.prefer;
                    end
                    // round robin from start, first hit wins
                    for (int s = 0; s < `MPCA_NUM_CH; s++) begin
                        probe = ch_step(start, s);
                        if (ch == ch_t'(`MPCA_NO_CH) && cap[probe] != '0) begin
                            ch = probe;
                        end
                    end
                    pivot = (ch != ch_t'(`MPCA_NO_CH)) ? ch_step(start, 1) : ch_step(start, 2);
                end
            end
            alloc[ranked.rank[i]] = ch;
            if (ch != ch_t'(`MPCA_NO_CH)) begin
                cap[ch] = cap[ch] - cap_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant_valid <= 1'b0;
        end else begin
            grant_valid <= rank_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rank_valid) begin
            grant_vec <= alloc;
        end
    end

endmodule

`default_nettype wire

/* hdl/grant_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpca_config.svh"

module grant_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 grant_valid,
    input  mpca_pkg::grant_vec_t grant_vec,
    input  logic                 out_credit,
    output logic                 out_valid,
    output mpca_pkg::grant_vec_t grant,
    output logic                 in_credit
);
    import mpca_pkg::*;

    typedef logic [$clog2(`MPCA_QUEUE_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(`MPCA_QUEUE_DEPTH+1)-1:0] count_t;
    typedef logic [$clog2(`MPCA_OUT_CREDITS+1)-1:0] credit_t;

    grant_vec_t mem [`MPCA_QUEUE_DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    count_t     count;
    credit_t    credits;
    logic       pop;

    // a pop frees a slot, so it returns an upstream credit too
    assign pop       = (count != '0) && (credits != '0);
    assign out_valid = pop;
    assign in_credit = pop;
    assign grant     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            mem[wr_ptr] <= grant_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= credit_t'(`MPCA_OUT_CREDITS);
        end else begin
            if (grant_valid) begin
                wr_ptr <= (wr_ptr == ptr_t'(`MPCA_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(`MPCA_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            case ({grant_valid, pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
            // downstream credits, spent per out_valid
            case ({out_credit, pop})
                2'b10:   credits <= credits + credit_t'(1);
                2'b01:   credits <= credits - credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/mpca_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mpca_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mpca_pkg::in_batch_t  in_batch,
    output logic                 in_credit,
    output logic                 out_valid,
    output mpca_pkg::grant_vec_t grant,
    input  logic                 out_credit
);
    import mpca_pkg::*;

    // stage links
    logic          req_valid;
    req_batch_t    req;
    logic          rank_valid;
    ranked_batch_t ranked;
    logic          grant_valid;
    grant_vec_t    grant_vec;

    packet_decrypt i_packet_decrypt (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_batch (in_batch),
        .req_valid(req_valid),
        .req      (req)
    );

    priority_sort i_priority_sort (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .rank_valid(rank_valid),
        .ranked    (ranked)
    );

    channel_allocator i_channel_allocator (
        .clk        (clk),
        .reset      (reset),
        .rank_valid (rank_valid),
        .ranked     (ranked),
        .grant_valid(grant_valid),
        .grant_vec  (grant_vec)
    );

    grant_queue i_grant_queue (
        .clk        (clk),
        .reset      (reset),
        .grant_valid(grant_valid),
        .grant_vec  (grant_vec),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .grant      (grant),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire

/* test/mpca_model.svh */
`ifndef MPCA_MODEL_SVH
`define MPCA_MODEL_SVH

// ====================
// random numbers
// ====================

logic [31:0] lcg_state;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// ====================
// cipher
// ====================

function automatic logic [15:0] rotr16(input logic [15:0] v, input int n);
    logic [31:0] d;
    d = {v, v} >> n;
    return d[15:0];
endfunction

function automatic logic [15:0] rotl16(input logic [15:0] v, input int n);
    logic [31:0] d;
    d = {v, v} << n;
    return d[31:16];
endfunction

// key r sits at bits 16r and up
function automatic logic [63:0] round_keys(input logic [63:0] key);
    logic [63:0] ks;
    logic [15:0] prev;
    prev = key[15:0];
    ks = 64'd0;
    ks[15:0] = prev;
    for (int r = 1; r < `MPCA_KEY_ROUNDS; r++) begin
        prev = (rotr16(prev, 7) + key[16*r +: 16]) ^ 16'(r - 1);
        ks[16*r +: 16] = prev;
    end
    return ks;
endfunction

// undoes the decrypt rounds, keys in rising order
function automatic logic [31:0] encrypt_pair(input logic [31:0] p, input logic [63:0] ks);
    logic [15:0] x;
    logic [15:0] y;
    x = p[15:0];
    y = p[31:16];
    for (int r = 0; r < `MPCA_KEY_ROUNDS; r++) begin
        x = (rotr16(x, 7) + y) ^ ks[16*r +: 16];
        y = rotl16(y, 2) ^ x;
    end
    return {y, x};
endfunction

function automatic logic [127:0] encrypt_batch(input logic [127:0] plain, input logic [63:0] key);
    logic [127:0] c;
    logic [63:0]  ks;
    ks = round_keys(key);
    for (int w = 0; w < 4; w++) begin
        c[32*w +: 32] = encrypt_pair(plain[32*w +: 32], ks);
    end
    return c;
endfunction

// ====================
// scoring and ranking
// ====================

function automatic int req_score(input logic [15:0] w);
    int q;
    int l;
    int c;
    int h;
    if (w[1]) begin
        q = int'($signed(w[14:13]));
        l = int'($signed(w[12:9]));
        c = int'($signed(w[8:7]));
        h = int'($signed(w[4:2]));
    end else begin
        q = int'(w[14:13]);
        l = int'(w[12:9]);
        c = int'(w[8:7]);
        h = int'(w[4:2]);
    end
    return 4 * q - 2 * l - 3 * c + h + 7;
endfunction

// one sort key: valid, then score, then lower index
function automatic logic [23:0] rank_order(input logic [127:0] plain);
    int          keyv [8];
    logic [7:0]  taken;
    logic [23:0] ord;
    int          best;
    for (int i = 0; i < 8; i++) begin
        keyv[i] = (plain[16*i + 15] ? 1024 : 0) + (req_score(plain[16*i +: 16]) + 64) * 8
                  + (7 - i);
    end
    taken = 8'd0;
    ord = 24'd0;
    for (int p = 0; p < 8; p++) begin
        best = -1;
        for (int i = 0; i < 8; i++) begin
            if (!taken[i] && (best < 0 || keyv[i] > keyv[best])) begin
                best = i;
            end
        end
        taken[best] = 1'b1;
        ord[3*p +: 3] = 3'(best);
    end
    return ord;
endfunction

// ====================
// allocation
// ====================

function automatic logic [15:0] allocate(input logic [127:0] plain, input logic [23:0] ord,
                                        input logic [8:0] cap);
    int          room [3];
    int          pivot;
    int          start;
    int          got;
    int          idx;
    int          pref;
    logic [15:0] gv;
    for (int c = 0; c < 3; c++) begin
        room[c] = int'(cap[3*c +: 3]);
    end
    pivot = -1;
    gv = {8{2'(`MPCA_NO_CH)}};
    for (int p = 0; p < 8; p++) begin
        idx = int'(ord[3*p +: 3]);
        pref = int'(plain[16*idx + 5 +: 2]);
        got = `MPCA_NO_CH;
        if (plain[16*idx + 15]) begin
            if (pref != `MPCA_NO_CH) begin
                if (room[pref] > 0) begin
                    got = pref;
                end
            end
            if (got == `MPCA_NO_CH) begin
                start = (pivot >= 0) ? pivot : ((pref == `MPCA_NO_CH) ? 0 : pref);
                for (int s = 0; s < 3; s++) begin
                    if (got == `MPCA_NO_CH && room[(start + s) % 3] > 0) begin
                        got = (start + s) % 3;
                    end
                end
                pivot = (got != `MPCA_NO_CH) ? (start + 1) % 3 : (start + 2) % 3;
            end
        end
        if (got != `MPCA_NO_CH) begin
            room[got] = room[got] - 1;
        end
        gv[2*idx +: 2] = 2'(got);
    end
    return gv;
endfunction

// grants follow from the plaintext requests
function automatic logic [15:0] expected_grant(input logic [127:0] plain,
                                              input logic [8:0] cap);
    return allocate(plain, rank_order(plain), cap);
endfunction

`endif

/* test/tb_mpca.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpca_config.svh"

module tb_mpca;
    import mpca_pkg::*;

    localparam int RAND_BATCHES  = 200;
    localparam int SORT_BATCHES  = 24;
    localparam int EMPTY_BATCHES = 16;
    localparam int HOLD_BATCHES  = `MPCA_QUEUE_DEPTH + `MPCA_OUT_CREDITS;
    localparam int CYCLE_LIMIT   =
        (RAND_BATCHES + SORT_BATCHES + EMPTY_BATCHES + HOLD_BATCHES) * 12 + 200;
    localparam logic [15:0] ALL_NO_CH = {`MPCA_NUM_REQ{2'(`MPCA_NO_CH)}};

    logic       clk;
    logic       reset;
    logic       in_valid;
    in_batch_t  in_batch;
    logic       in_credit;
    logic       out_valid;
    grant_vec_t grant;
    logic       out_credit;

    // main process side
    logic [15:0] exp_q [$];
    int          sent_total = 0;
    int          returned = 0;
    logic        hold = 1'b0;
    int          checks = 0;
    int          errors = 0;
    // monitor side
    int          delivered = 0;
    int          credit_pulses = 0;
    int          mon_checks = 0;
    int          mon_errors = 0;
    int          cycles = 0;

    `include "mpca_model.svh"

    mpca_top i_mpca_top (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_batch  (in_batch),
        .in_credit (in_credit),
        .out_valid (out_valid),
        .grant     (grant),
        .out_credit(out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ====================
    // output monitor
    // ====================

    always @(negedge clk) begin
        if (!reset && out_valid === 1'b1) begin
            mon_checks++;
            if (delivered >= exp_q.size()) begin
                $display("grant delivered with no batch outstanding");
                mon_errors++;
            end else if (grant !== exp_q[delivered]) begin
                $display("Error: grant expected 0x%04h got 0x%04h", exp_q[delivered], grant);
                mon_errors++;
            end
            delivered++;
        end
        if (!reset && in_credit === 1'b1) begin
            credit_pulses++;
        end
    end

    function automatic int total_errors();
        return errors + mon_errors;
    endfunction

    function automatic int source_credits();
        return `MPCA_QUEUE_DEPTH - sent_total + credit_pulses;
    endfunction

    function automatic logic [127:0] rand_wide();
        logic [127:0] v;
        for (int w = 0; w < 4; w++) begin
            v[32*w +: 32] = lcg_next();
        end
        return v;
    endfunction

    function automatic logic [63:0] rand_key();
        logic [31:0] lo;
        logic [31:0] hi;
        lo = lcg_next();
        hi = lcg_next();
        return {hi, lo};
    endfunction

    function automatic logic [15:0] make_req(input logic valid, input logic [1:0] qos,
                                             input logic [3:0] len, input logic [1:0] cong,
                                             input logic [1:0] prefer, input logic [2:0] hint,
                                             input logic mode);
        return {valid, qos, len, cong, prefer, hint, mode, 1'b0};
    endfunction

    // consumer hands back one credit per cycle for each grant taken
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (!hold && returned < delivered) begin
            out_credit = 1'b1;
            returned++;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    task automatic send_batch(input logic [127:0] packets, input logic [8:0] cap,
                              input logic [63:0] key, input logic [15:0] want);
        while (source_credits() == 0) begin
            next_cycle();
        end
        in_valid = 1'b1;
        in_batch = {packets, cap, key};
        exp_q.push_back(want);
        sent_total++;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic send_plain(input logic [127:0] plain, input logic [8:0] cap,
                              input logic [63:0] key);
        send_batch(encrypt_batch(plain, key), cap, key, expected_grant(plain, cap));
    endtask

    task automatic wait_drain();
        while (delivered < sent_total || returned < delivered) begin
            next_cycle();
        end
        repeat (3) next_cycle();
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, total_errors() - err_before);
    endtask

    // ====================
    // test sequence
    // ====================

    initial begin
        logic [127:0] plain;
        logic [8:0]   cap;
        logic [63:0]  key;
        logic [31:0]  r;
        logic [31:0]  f;
        int           pref;
        int           t_err;
        int           sent;
        int           deliv0;
        int           pulses0;
        lcg_state = 32'hde70_8215;
        reset = 1'b1;
        in_valid = 1'b0;
        in_batch = '0;
        out_credit = 1'b0;
        repeat (5) next_cycle();
        reset = 1'b0;

        // idle after reset
        t_err = total_errors();
        repeat (10) begin
            next_cycle();
            checks += 2;
            if (out_valid !== 1'b0) begin
                $display("Error: out_valid expected 0x0 got 0x%0h", out_valid);
                errors++;
            end
            if (in_credit !== 1'b0) begin
                $display("Error: in_credit expected 0x0 got 0x%0h", in_credit);
                errors++;
            end
        end
        report_test("test 1 idle after reset", t_err);

        t_err = total_errors();
        for (int b = 0; b < RAND_BATCHES; b++) begin
            plain = rand_wide();
            r = lcg_next();
            cap = r[24:16];
            key = rand_key();
            send_plain(plain, cap, key);
        end
        wait_drain();
        report_test("test 2 random batches", t_err);

        // one shared preferred channel of capacity 2
        t_err = total_errors();
        for (int b = 0; b < SORT_BATCHES; b++) begin
            r = lcg_next();
            pref = int'(r[31:16] % 16'd3);
            cap = r[8:0];
            cap[3*pref +: 3] = 3'd2;
            f = lcg_next();
            for (int i = 0; i < 8; i++) begin
                r = lcg_next();
                if (b % 2 == 0) begin
                    // top bits clear so both modes read the same score
                    plain[16*i +: 16] = make_req(r[31:29] != 3'd0, {1'b0, f[20]},
                                                 {1'b0, f[19:17]}, {1'b0, f[16]}, 2'(pref),
                                                 {1'b0, f[15:14]}, r[28]);
                end else begin
                    plain[16*i +: 16] = make_req(r[31:29] != 3'd0, r[27:26], r[25:22],
                                                 r[21:20], 2'(pref), r[19:17], r[16]);
                end
            end
            key = rand_key();
            send_plain(plain, cap, key);
        end
        wait_drain();
        report_test("test 3 sort and fallback", t_err);

        t_err = total_errors();
        for (int b = 0; b < EMPTY_BATCHES; b++) begin
            plain = rand_wide();
            r = lcg_next();
            key = rand_key();
            if (b < EMPTY_BATCHES / 2) begin
                cap = 9'd0;
            end else begin
                cap = r[8:0];
                for (int i = 0; i < 8; i++) begin
                    plain[16*i + 15] = 1'b0;
                end
            end
            send_batch(encrypt_batch(plain, key), cap, key, ALL_NO_CH);
        end
        wait_drain();
        report_test("test 4 nothing granted", t_err);

        // back-pressure from the consumer
        t_err = total_errors();
        deliv0 = delivered;
        pulses0 = credit_pulses;
        sent = 0;
        hold = 1'b1;
        repeat (40) begin
            if (source_credits() > 0) begin
                plain = rand_wide();
                r = lcg_next();
                key = rand_key();
                send_plain(plain, r[8:0], key);
                sent++;
            end else begin
                next_cycle();
            end
        end
        checks++;
        if (delivered - deliv0 > `MPCA_OUT_CREDITS) begin
            $display("more grants delivered than downstream credits while out_credit was held");
            errors++;
        end
        hold = 1'b0;
        wait_drain();
        checks += 2;
        if (delivered - deliv0 != sent) begin
            $display("grants lost after out_credit resumed");
            errors++;
        end
        if (credit_pulses - pulses0 != delivered - deliv0) begin
            $display("in_credit pulse count differs from grants delivered");
            errors++;
        end
        report_test("test 5 back-pressure", t_err);

        $display("%0d checks, %0d errors", checks + mon_checks, total_errors());
        if (total_errors() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
+incdir+test
hdl/mpca_pkg.sv
hdl/packet_decrypt.sv
hdl/priority_sort.sv
hdl/channel_allocator.sv
hdl/grant_queue.sv
hdl/mpca_top.sv
test/tb_mpca.sv

/* Makefile */
SRCS := $(shell grep -v '^+' project.f)
HDRS := $(wildcard hdl/*.svh test/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_mpca
	@out="$$(./obj_dir/Vtb_mpca)"; echo "$$out"; \
	echo "$$out" | grep -qx 'ALL CHECKS PASSED'

obj_dir/Vtb_mpca: project.f $(SRCS) $(HDRS)
	verilator --binary -j 0 --top-module tb_mpca -Mdir obj_dir -f project.f

clean:
	rm -rf obj_dir
